//--- rtl/peakFinder_defs.svh
`ifndef PEAKFINDER_DEFS_SVH
`define PEAKFINDER_DEFS_SVH

// histogram geometry
`define NP 12 // sample width
`define NB 4 // bin index width, 16 bins per histogram
`define PIXEL_NUM 4
`define DATA_NUM 4 // samples per pixel per acquisition
`define ACQ_NUM 4 // acquisitions per pass
`define COUNT_W 8 // bin count, saturating
`define DRAIN_CYCLES 2 // depth of the update pipeline

// derived window geometry
`define BIN_NUM (1 << `NB)
`define COARSE_SHIFT (`NP - `NB) // log2 of coarse bin width
`define FINE_SHIFT (`NP - 2 * `NB + 1) // log2 of fine bin width
`define HALF_COARSE (1 << (`COARSE_SHIFT - 1))
`define WIN_SPAN (1 << (`COARSE_SHIFT + 1)) // two coarse bins
`define WIN_START_MAX ((1 << `NP) - `WIN_SPAN)

`endif

//--- rtl/peakPkg.sv
`include "peakFinder_defs.svh"

package peakPkg;

    typedef logic [`NP-1:0] sample_t; // raw timestamp
    typedef logic [`NB-1:0] binIdx_t;
    typedef logic [1:0] pixIdx_t;
    typedef logic [`COUNT_W-1:0] count_t;

    typedef enum logic {
        PASS_COARSE,
        PASS_FINE
    } passSel_e;

    // a sample split at the coarse bin boundary
    typedef struct packed {
        binIdx_t coarseBin; // top NB bits
        logic [`COARSE_SHIFT-1:0] offset; // position inside the coarse bin
    } sampleFields_t;

    typedef union packed {
        sample_t raw;
        sampleFields_t f;
    } sampleWord_u;

endpackage

//--- rtl/passCtrlIf.sv
`timescale 1ns/1ns

interface passCtrlIf import peakPkg::*; ();

    passSel_e pass; // histogram currently being built
    logic sampleFire; // sample accepted this cycle
    logic drainStart;
    logic countClear;
    logic passEnd; // accepted sample closes the pass
    logic drainDone;
    pixIdx_t pixel; // pixel owning the offered sample

    modport fsm (
        output pass, sampleFire, drainStart, countClear,
        input passEnd, drainDone, pixel
    );

    modport cnt (
        input sampleFire, drainStart, countClear,
        output passEnd, drainDone, pixel
    );

endinterface

//--- rtl/histUpdateIf.sv
`timescale 1ns/1ns

interface histUpdateIf import peakPkg::*; ();

    // mapper to memory
    logic upd;
    pixIdx_t pixel;
    binIdx_t bin;
    logic clearAll; // empties histograms and peak state

    // memory to tracker
    logic cntValid;
    pixIdx_t cntPixel;
    binIdx_t cntBin;
    count_t count; // bin count after the increment

    modport mapper (
        output upd, pixel, bin, clearAll
    );

    modport ram (
        input upd, pixel, bin, clearAll,
        output cntValid, cntPixel, cntBin, count
    );

    modport tracker (
        input cntValid, cntPixel, cntBin, count, clearAll
    );

endinterface

//--- rtl/passControlFsm.sv
`timescale 1ns/1ns

module passControlFsm import peakPkg::*; (
    input logic clk,
    input logic combin_res,
    input logic sampleValid,
    output logic ready,
    output logic resultValid,
    passCtrlIf.fsm ctl,
    output logic clearAll
);

    typedef enum logic [2:0] {
        COARSE,
        DRAIN,
        WINDOW,
        FINE,
        REPORT
    } state_e;

    state_e state;
    state_e nextState;
    passSel_e passSel; // pass the drain belongs to
    logic betweenPasses;

    assign ready = (state == COARSE) || (state == FINE);
    assign ctl.sampleFire = ready && sampleValid;
    assign ctl.drainStart = ctl.sampleFire && ctl.passEnd;
    assign ctl.pass = passSel;

    // window set-up and report both reset the histograms
    assign betweenPasses = (state == WINDOW) || (state == REPORT);
    assign ctl.countClear = betweenPasses;
    assign clearAll = betweenPasses;

    assign resultValid = (state == REPORT); // result is formed in this cycle

    always_comb begin
        nextState = state;
        case (state)
            COARSE, FINE: begin
                if (ctl.drainStart) begin
                    nextState = DRAIN;
                end
            end
            DRAIN: begin
                if (ctl.drainDone) begin
                    nextState = (passSel == PASS_COARSE) ? WINDOW : REPORT;
                end
            end
            WINDOW: nextState = FINE;
            REPORT: nextState = COARSE; // next frame
            default: nextState = COARSE;
        endcase
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= COARSE;
            passSel <= PASS_COARSE;
        end else begin
            state <= nextState;
            if (state == WINDOW) begin
                passSel <= PASS_FINE;
            end else if (state == REPORT) begin
                passSel <= PASS_COARSE;
            end
        end
    end

endmodule

//--- rtl/sampleCounter.sv
`timescale 1ns/1ns
`include "peakFinder_defs.svh"

module sampleCounter import peakPkg::*; (
    input logic clk,
    input logic combin_res,
    passCtrlIf.cnt ctl
);

    localparam int DATA_W = $clog2(`DATA_NUM);
    localparam int ACQ_W = $clog2(`ACQ_NUM);
    localparam int DRAIN_W = $clog2(`DRAIN_CYCLES + 1);

    logic [DATA_W-1:0] dataCnt; // sample within pixel
    pixIdx_t pixelCnt;
    logic [ACQ_W-1:0] acqCnt;
    logic [DRAIN_W-1:0] drainCnt;
    logic dataLast;
    logic pixelLast;
    logic acqLast;

    assign dataLast = (dataCnt == DATA_W'(`DATA_NUM - 1));
    assign pixelLast = (pixelCnt == pixIdx_t'(`PIXEL_NUM - 1));
    assign acqLast = (acqCnt == ACQ_W'(`ACQ_NUM - 1));

    assign ctl.passEnd = dataLast && pixelLast && acqLast;
    assign ctl.pixel = pixelCnt;
    assign ctl.drainDone = (drainCnt == DRAIN_W'(1)); // leaves drain on the next edge

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            dataCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
        end else if (ctl.countClear) begin
            dataCnt <= '0;
            pixelCnt <= '0;
            acqCnt <= '0;
        end else if (ctl.sampleFire) begin
            if (!dataLast) begin
                dataCnt <= dataCnt + 1'b1;
            end else begin
                dataCnt <= '0;
                if (!pixelLast) begin
                    pixelCnt <= pixelCnt + 1'b1;
                end else begin
                    pixelCnt <= '0;
                    acqCnt <= acqLast ? '0 : acqCnt + 1'b1; // wraps at pass end
                end
            end
        end
    end

    // drain timer, counts down once per cycle
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            drainCnt <= '0;
        end else if (ctl.drainStart) begin
            drainCnt <= DRAIN_W'(`DRAIN_CYCLES);
        end else if (drainCnt != '0) begin
            drainCnt <= drainCnt - 1'b1;
        end
    end

endmodule

//--- rtl/binMapper.sv
`timescale 1ns/1ns
`include "peakFinder_defs.svh"

module binMapper import peakPkg::*; (
    input logic clk,
    input logic combin_res,
    input sample_t sample,
    input logic sampleFire,
    input passSel_e pass,
    input pixIdx_t pixel,
    input logic latchWindow,
    input binIdx_t peakBin [`PIXEL_NUM],
    output sample_t windowStart [`PIXEL_NUM],
    histUpdateIf.mapper hu
);

    sampleWord_u inWord;
    sampleWord_u offsetWord; // sample relative to its window
    sample_t winLow;
    logic inWindow;
    binIdx_t nextBin;

    // window start for a coarse peak, clamped to the sample range
    function automatic sample_t calcStart(binIdx_t peak);
        sampleWord_u binBase;
        sample_t lowEdge;
        binBase.f.coarseBin = peak;
        binBase.f.offset = '0;
        if (binBase.raw < sample_t'(`HALF_COARSE)) begin
            lowEdge = '0; // bottom clamp
        end else begin
            lowEdge = binBase.raw - sample_t'(`HALF_COARSE);
        end
        if (lowEdge > sample_t'(`WIN_START_MAX)) begin
            lowEdge = sample_t'(`WIN_START_MAX); // top clamp
        end
        return lowEdge;
    endfunction

    always_comb begin
        inWord.raw = sample;
        winLow = windowStart[pixel];
        offsetWord.raw = inWord.raw - winLow; // wraps high below the window
        inWindow = (inWord.raw >= winLow)
            && (offsetWord.raw < sample_t'(`WIN_SPAN));
        if (pass == PASS_COARSE) begin
            nextBin = inWord.f.coarseBin;
        end else begin
            nextBin = offsetWord.raw[`FINE_SHIFT +: `NB];
        end
    end

    // high in both window and report cycles
    assign hu.clearAll = latchWindow;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hu.upd <= 1'b0;
        end else begin
            hu.upd <= sampleFire && ((pass == PASS_COARSE) || inWindow); // drop strays
        end
    end

    always_ff @(posedge clk) begin
        hu.pixel <= pixel;
        hu.bin <= nextBin;
    end

    // windows only come from coarse peaks
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                windowStart[p] <= '0;
            end
        end else if (latchWindow && (pass == PASS_COARSE)) begin
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                windowStart[p] <= calcStart(peakBin[p]);
            end
        end
    end

endmodule

//--- rtl/histogramRam.sv
`timescale 1ns/1ns
`include "peakFinder_defs.svh"

module histogramRam import peakPkg::*; (
    input logic clk,
    input logic combin_res,
    histUpdateIf.ram hu
);

    localparam int DEPTH = `PIXEL_NUM * `BIN_NUM;
    localparam int ADDR_W = $clog2(DEPTH);

    count_t binMem [DEPTH]; // one histogram per pixel
    logic [DEPTH-1:0] binValid; // cleared bins read as zero
    logic [ADDR_W-1:0] addr;
    count_t oldCount;
    count_t newCount;

    assign addr = {hu.pixel, hu.bin};

    always_comb begin
        oldCount = binValid[addr] ? binMem[addr] : '0;
        if (oldCount == '1) begin
            newCount = oldCount; // saturate
        end else begin
            newCount = oldCount + 1'b1;
        end
    end

    // new count goes straight on to the tracker
    assign hu.cntValid = hu.upd;
    assign hu.cntPixel = hu.pixel;
    assign hu.cntBin = hu.bin;
    assign hu.count = newCount;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
        end else if (hu.clearAll) begin
            binValid <= '0; // all histograms empty in one cycle
        end else if (hu.upd) begin
            binValid[addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (hu.upd) begin
            binMem[addr] <= newCount; // in place, so back-to-back hits add up
        end
    end

endmodule

//--- rtl/peakTracker.sv
`timescale 1ns/1ns
`include "peakFinder_defs.svh"

module peakTracker import peakPkg::*; (
    input logic clk,
    input logic combin_res,
    histUpdateIf.tracker hu,
    output binIdx_t peakBin [`PIXEL_NUM],
    input sample_t windowStart [`PIXEL_NUM],
    input logic report,
    output logic [`PIXEL_NUM*`NP-1:0] result
);

    count_t maxCount [`PIXEL_NUM];
    logic [`PIXEL_NUM*`NP-1:0] formed;
    logic [`PIXEL_NUM*`NP-1:0] resultHeld;

    // centre of the fine peak bin
    function automatic sample_t finePos(sample_t start, binIdx_t bin);
        sample_t binOffset;
        binOffset = sample_t'(bin) << `FINE_SHIFT;
        return start + binOffset + sample_t'(1 << (`FINE_SHIFT - 1));
    endfunction

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                maxCount[p] <= '0;
                peakBin[p] <= '0;
            end
        end else if (hu.clearAll) begin
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                maxCount[p] <= '0;
                peakBin[p] <= '0;
            end
        end else if (hu.cntValid && (hu.count > maxCount[hu.cntPixel])) begin
            maxCount[hu.cntPixel] <= hu.count; // ties keep the earlier bin
            peakBin[hu.cntPixel] <= hu.cntBin;
        end
    end

    always_comb begin
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            formed[p*`NP +: `NP] = finePos(windowStart[p], peakBin[p]);
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            resultHeld <= '0;
        end else if (report) begin
            resultHeld <= formed; // peak state clears on this edge
        end
    end

    assign result = report ? formed : resultHeld;

endmodule

//--- rtl/tdcPeakFinder.sv
`timescale 1ns/1ns
`include "peakFinder_defs.svh"

module tdcPeakFinder import peakPkg::*; (
    input logic clk,
    input logic combin_res,
    input logic sampleValid,
    input logic [`NP-1:0] sample,
    output logic ready,
    output logic resultValid,
    output logic [`PIXEL_NUM*`NP-1:0] result
);

    passCtrlIf ctlIf ();
    histUpdateIf huIf ();

    binIdx_t peakBin [`PIXEL_NUM]; // tracker to mapper
    sample_t windowStart [`PIXEL_NUM]; // mapper to tracker
    logic clearAll;

    passControlFsm uFsm (
        .clk(clk),
        .combin_res(combin_res),
        .sampleValid(sampleValid),
        .ready(ready),
        .resultValid(resultValid),
        .ctl(ctlIf.fsm),
        .clearAll(clearAll)
    );

    sampleCounter uCounter (
        .clk(clk),
        .combin_res(combin_res),
        .ctl(ctlIf.cnt)
    );

    binMapper uMapper (
        .clk(clk),
        .combin_res(combin_res),
        .sample(sample),
        .sampleFire(ctlIf.sampleFire),
        .pass(ctlIf.pass),
        .pixel(ctlIf.pixel),
        .latchWindow(clearAll),
        .peakBin(peakBin),
        .windowStart(windowStart),
        .hu(huIf.mapper)
    );

    histogramRam uRam (
        .clk(clk),
        .combin_res(combin_res),
        .hu(huIf.ram)
    );

    peakTracker uTracker (
        .clk(clk),
        .combin_res(combin_res),
        .hu(huIf.tracker),
        .peakBin(peakBin),
        .windowStart(windowStart),
        .report(resultValid), // report cycle
        .result(result)
    );

endmodule

//--- tb/tdcPeakFinderTb.sv
`timescale 1ns/1ns
`include "peakFinder_defs.svh"

module tdcPeakFinderTb import peakPkg::*; ();

    localparam int PASS_LEN = `ACQ_NUM * `PIXEL_NUM * `DATA_NUM; // samples per pass
    localparam int COARSE_W = 1 << (`NP - `NB);
    localparam int FINE_W = 2 * COARSE_W / (1 << `NB);
    localparam int FRAMES = 6;
    localparam int WATCH_NS = FRAMES * 2 * PASS_LEN * 3 * 20 + 2000; // reset and margin

    logic clk;
    logic combin_res;
    logic sampleValid;
    sample_t sample;
    logic ready;
    logic resultValid;
    logic [`PIXEL_NUM*`NP-1:0] result;

    logic [31:0] lfsrState;
    sample_t coarseSeq [PASS_LEN];
    sample_t fineSeq [PASS_LEN];
    sample_t expResult [`PIXEL_NUM];
    logic [`PIXEL_NUM*`NP-1:0] capturedResult; // result seen during the strobe
    int strobeCount;
    int framesRun;
    int valueErrors;
    int protocolErrors;

    tdcPeakFinder dut (
        .clk(clk),
        .combin_res(combin_res),
        .sampleValid(sampleValid),
        .sample(sample),
        .ready(ready),
        .resultValid(resultValid),
        .result(result)
    );

    always #10 clk = ~clk;

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (resultValid) begin
            strobeCount++;
            capturedResult = result;
        end
    end

    function automatic int randBits(int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | int'(lfsrState[0]);
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
        end
        return v;
    endfunction

    task automatic checkSample(input sample_t got, input sample_t exp, input string what);
        if (got !== exp) begin
            valueErrors++;
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic checkBit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            valueErrors++;
            $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // mode 0 edge constants, 1 clusters, 2 tied counts, 3 strays in the fine pass
    task automatic makeFrame(input int mode);
        sample_t center [`PIXEL_NUM];
        sample_t alt [`PIXEL_NUM];
        sample_t edges [`PIXEL_NUM];
        int p;
        edges = '{12'd5, 12'd300, 12'd3990, 12'd4090}; // both clamps
        for (int q = 0; q < `PIXEL_NUM; q++) begin
            center[q] = sample_t'(randBits(`NP));
            alt[q] = center[q] ^ 12'h400; // lands in another coarse bin
        end
        for (int i = 0; i < PASS_LEN; i++) begin
            p = (i / `DATA_NUM) % `PIXEL_NUM;
            if (mode == 0) begin
                coarseSeq[i] = edges[p];
                fineSeq[i] = edges[p];
            end else if (mode == 2) begin
                coarseSeq[i] = i[0] ? center[p] : alt[p]; // alt reaches each count first
                fineSeq[i] = i[0] ? alt[p] : alt[p] + 12'd40;
            end else begin
                coarseSeq[i] = randBits(1) ? center[p] + sample_t'(randBits(5))
                    : sample_t'(randBits(`NP));
                if (mode == 3 && randBits(2) != 0) begin
                    fineSeq[i] = center[p] ^ 12'h800; // far outside the window
                end else if (mode == 3 || randBits(1)) begin
                    fineSeq[i] = center[p] + sample_t'(randBits(5));
                end else begin
                    fineSeq[i] = sample_t'(randBits(`NP));
                end
            end
        end
    endtask

    // reference model, both passes in arrival order
    task automatic predict();
        int cnt [`PIXEL_NUM][1 << `NB];
        int maxCnt [`PIXEL_NUM];
        int peak [`PIXEL_NUM];
        int low [`PIXEL_NUM];
        sampleWord_u w;
        int p;
        int b;
        int off;
        for (int passNo = 0; passNo < 2; passNo++) begin
            for (int q = 0; q < `PIXEL_NUM; q++) begin
                maxCnt[q] = 0;
                peak[q] = 0;
                for (int k = 0; k < (1 << `NB); k++) begin
                    cnt[q][k] = 0;
                end
            end
            for (int i = 0; i < PASS_LEN; i++) begin
                p = (i / `DATA_NUM) % `PIXEL_NUM;
                if (passNo == 0) begin
                    w.raw = coarseSeq[i];
                    b = int'(w.f.coarseBin);
                end else begin
                    w.raw = fineSeq[i];
                    off = int'(w.raw) - low[p];
                    b = (off >= 0 && off < 2 * COARSE_W) ? off / FINE_W : -1;
                end
                if (b >= 0) begin
                    if (cnt[p][b] < (1 << `COUNT_W) - 1) begin
                        cnt[p][b]++;
                    end
                    if (cnt[p][b] > maxCnt[p]) begin // strictly greater, ties keep old bin
                        maxCnt[p] = cnt[p][b];
                        peak[p] = b;
                    end
                end
            end
            if (passNo == 0) begin
                for (int q = 0; q < `PIXEL_NUM; q++) begin
                    low[q] = peak[q] * COARSE_W - COARSE_W / 2;
                    if (low[q] < 0) begin
                        low[q] = 0;
                    end
                    if (low[q] > (1 << `NP) - 2 * COARSE_W) begin
                        low[q] = (1 << `NP) - 2 * COARSE_W;
                    end
                end
            end
        end
        for (int q = 0; q < `PIXEL_NUM; q++) begin
            expResult[q] = sample_t'(low[q] + peak[q] * FINE_W + FINE_W / 2);
        end
    endtask

    // called and returns 2 ns after a rising edge
    task automatic sendSample(input sample_t v, input logic gaps);
        if (gaps && randBits(1)) begin
            sampleValid = 1'b0; // idle cycle
            @(posedge clk);
            #2;
        end
        while (!ready) begin
            sampleValid = gaps; // offered while stalled, must be ignored
            if (gaps) begin
                sample = sample_t'(randBits(`NP));
            end
            @(posedge clk);
            #2;
        end
        sampleValid = 1'b1;
        sample = v;
        @(posedge clk);
        #2;
        sampleValid = 1'b0;
    endtask

    task automatic checkResetState();
        checkBit(ready, 1'b1, "ready after reset");
        checkBit(resultValid, 1'b0, "resultValid after reset");
        for (int q = 0; q < `PIXEL_NUM; q++) begin
            checkSample(result[q*`NP +: `NP], '0, $sformatf("result pixel %0d after reset", q));
        end
    endtask

    task automatic runFrame(input int mode, input logic gaps, input string name);
        int target;
        makeFrame(mode);
        predict();
        target = framesRun + 1;
        for (int i = 0; i < PASS_LEN; i++) begin
            sendSample(coarseSeq[i], gaps);
        end
        for (int i = 0; i < PASS_LEN; i++) begin
            sendSample(fineSeq[i], gaps);
        end
        for (int c = 0; c < 4 * `DRAIN_CYCLES + 8 && strobeCount < target; c++) begin
            @(posedge clk);
            #2;
        end
        framesRun++;
        if (strobeCount < target) begin
            protocolErrors++;
            $display("%s: resultValid never came after the fine pass", name);
            return;
        end
        checkBit(resultValid, 1'b0, $sformatf("%s resultValid after report", name));
        if (strobeCount != target) begin
            protocolErrors++;
            $display("%s: saw %0d result strobes in total, wanted %0d", name, strobeCount, target);
        end
        for (int q = 0; q < `PIXEL_NUM; q++) begin
            checkSample(capturedResult[q*`NP +: `NP], expResult[q],
                $sformatf("%s pixel %0d result", name, q));
            checkSample(result[q*`NP +: `NP], expResult[q],
                $sformatf("%s pixel %0d held result", name, q));
        end
    endtask

    initial begin
        clk = 1'b0;
        combin_res = 1'b0;
        sampleValid = 1'b0;
        sample = '0;
        lfsrState = 32'h7bc3_64c1;
        strobeCount = 0;
        framesRun = 0;
        valueErrors = 0;
        protocolErrors = 0;
        repeat (10) @(posedge clk);
        #2;
        combin_res = 1'b1;
        checkResetState();
        runFrame(0, 1'b0, "edge values");
        runFrame(1, 1'b0, "cluster frame 1");
        runFrame(1, 1'b0, "cluster frame 2"); // histograms must start empty again
        runFrame(2, 1'b0, "tied counts");
        runFrame(3, 1'b0, "fine strays");
        runFrame(1, 1'b1, "gaps and stalls");
        $display("errors: %0d value, %0d protocol", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCH_NS);
        $display("watchdog: run did not finish within %0d ns", WATCH_NS);
        $display("Test failed");
        $finish;
    end

endmodule

//--- tdcPeakFinder.f
+incdir+rtl
rtl/peakPkg.sv
rtl/passCtrlIf.sv
rtl/histUpdateIf.sv
rtl/passControlFsm.sv
rtl/sampleCounter.sv
rtl/binMapper.sv
rtl/histogramRam.sv
rtl/peakTracker.sv
rtl/tdcPeakFinder.sv
tb/tdcPeakFinderTb.sv

//--- Makefile
VERILATOR ?= verilator
TB_TOP ?= tdcPeakFinderTb
FILELIST ?= tdcPeakFinder.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --timescale 1ns/1ns

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then \
		echo "no pass message in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
